// ==== compile.f ====
logic/bpu_pkg.sv
logic/ram_array.sv
logic/bypass_ram.sv
logic/btb.sv
logic/pht.sv
logic/bpu_top.sv
dv/bpu_asserts.sv
dv/bpu_tb.sv

// ==== dv/bpu_asserts.sv ====
module bpu_asserts (
    input logic                     clk,
    input logic                     rst_n_i,
    input logic                     lookup_i,
    input logic [bpu_pkg::XLEN-1:0] lookup_pc_i,
    input logic                     pred_valid_i,
    input logic                     pred_hit_i,
    input logic                     pred_taken_i,
    input logic [bpu_pkg::XLEN-1:0] pred_target_i
);

    timeunit 1ns;
    timeprecision 1ps;

    // one prediction per lookup, exactly one cycle later
    a_valid_latency: assert property (@(posedge clk) disable iff (!rst_n_i)
                                      pred_valid_i == $past(lookup_i))
        else $error("prediction strobe does not follow the lookup strobe");

    a_valid_in_reset: assert property (@(posedge clk) !rst_n_i |-> !pred_valid_i)
        else $error("prediction strobe high during reset");

    a_valid_after_reset: assert property (@(posedge clk) $rose(rst_n_i) |-> !pred_valid_i)
        else $error("prediction strobe high right after reset");

    a_taken_needs_hit: assert property (@(posedge clk) disable iff (!rst_n_i)
                                        pred_taken_i |-> pred_hit_i)
        else $error("taken prediction without a btb hit");

    // fall-through target on a miss
    a_miss_target: assert property (@(posedge clk) disable iff (!rst_n_i)
                                    pred_valid_i && !pred_hit_i
                                    |-> pred_target_i == $past(lookup_pc_i) + 32'd4)
        else $error("miss target is not the lookup pc plus 4");

endmodule

bind bpu_top bpu_asserts u_asserts (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .lookup_i      (lookup_i),
    .lookup_pc_i   (lookup_pc_i),
    .pred_valid_i  (pred_valid_o),
    .pred_hit_i    (pred_hit_o),
    .pred_taken_i  (pred_taken_o),
    .pred_target_i (pred_target_o)
);

// ==== dv/bpu_tb.sv ====
module bpu_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int IDX_W        = 6;
    localparam int OFF_W        = 2;
    localparam int DEPTH        = 1 << IDX_W;
    localparam int RESET_CYCLES = 4;
    localparam int RAND_CYCLES  = 1900;
    localparam int MAX_CYCLES   = 3000; // reset, ~40 directed and 1900 random cycles, with margin

    // pairs 0/1, 2/3 and 4/5 share an index with different tags
    localparam logic [31:0] PC_POOL [8] = '{
        32'h0000_1000, 32'h0000_2000, 32'h0000_1004, 32'h0040_1004,
        32'h0000_10fc, 32'h0001_10fc, 32'h0000_1040, 32'h0000_3080
    };

    logic                     clk = 1'b0;
    logic                     rst_n_i;
    logic                     lookup_i;
    logic [bpu_pkg::XLEN-1:0] lookup_pc_i;
    logic                     upd_i;
    logic [bpu_pkg::XLEN-1:0] upd_pc_i;
    logic                     upd_taken_i;
    logic [bpu_pkg::XLEN-1:0] upd_target_i;
    logic [1:0]               upd_ctr_i;
    logic                     pred_valid_o;
    logic                     pred_hit_o;
    logic                     pred_taken_o;
    logic [bpu_pkg::XLEN-1:0] pred_target_o;
    logic [1:0]               pred_ctr_o;

    // reference model state
    logic             m_valid   [DEPTH];
    logic [31:0]      m_tag     [DEPTH];
    logic [31:0]      m_target  [DEPTH];
    logic             m_written [DEPTH];
    logic [1:0]       m_ctr     [DEPTH];
    logic [IDX_W-1:0] u_idx;
    logic [IDX_W-1:0] l_idx;
    logic             l_hit;
    logic [1:0]       l_ctr;

    logic        exp_valid;
    logic        exp_hit;
    logic        exp_taken;
    logic [31:0] exp_target;
    logic [1:0]  exp_ctr;

    integer seed        = 25826;
    int     cycle_count = 0;
    int     pred_count  = 0;

    always #50 clk = ~clk;

    bpu_top #(
        .IDX_W (IDX_W)
    ) DUT (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .lookup_i      (lookup_i),
        .lookup_pc_i   (lookup_pc_i),
        .upd_i         (upd_i),
        .upd_pc_i      (upd_pc_i),
        .upd_taken_i   (upd_taken_i),
        .upd_target_i  (upd_target_i),
        .upd_ctr_i     (upd_ctr_i),
        .pred_valid_o  (pred_valid_o),
        .pred_hit_o    (pred_hit_o),
        .pred_taken_o  (pred_taken_o),
        .pred_target_o (pred_target_o),
        .pred_ctr_o    (pred_ctr_o)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    function automatic logic [IDX_W-1:0] pc_index(input logic [31:0] pc);
        return pc[IDX_W+OFF_W-1:OFF_W];
    endfunction

    function automatic logic [31:0] pc_tag(input logic [31:0] pc);
        return pc >> (IDX_W + OFF_W);
    endfunction

    function automatic logic [1:0] counter_of(input logic [IDX_W-1:0] idx);
        return m_written[idx] ? m_ctr[idx] : 2'd1; // weakly not taken until written
    endfunction

    function automatic logic [1:0] step_counter(input logic [1:0] ctr, input logic taken);
        if (taken && ctr != 2'd3) begin
            return ctr + 2'd1;
        end
        if (!taken && ctr != 2'd0) begin
            return ctr - 2'd1;
        end
        return ctr;
    endfunction

    always @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                m_valid[i]   = 1'b0;
                m_written[i] = 1'b0;
            end
            exp_valid <= 1'b0;
        end else begin
            if (upd_i) begin
                u_idx            = pc_index(upd_pc_i);
                m_ctr[u_idx]     = step_counter(upd_ctr_i, upd_taken_i);
                m_written[u_idx] = 1'b1;
                if (upd_taken_i) begin
                    m_valid[u_idx]  = 1'b1;
                    m_tag[u_idx]    = pc_tag(upd_pc_i);
                    m_target[u_idx] = upd_target_i;
                end
            end
            // update lands first so a colliding lookup sees it
            exp_valid <= lookup_i;
            if (lookup_i) begin
                l_idx = pc_index(lookup_pc_i);
                l_hit = m_valid[l_idx] && (m_tag[l_idx] == pc_tag(lookup_pc_i));
                l_ctr = counter_of(l_idx);
                exp_hit    <= l_hit;
                exp_ctr    <= l_ctr;
                exp_taken  <= l_hit && l_ctr[1];
                exp_target <= l_hit ? m_target[l_idx] : lookup_pc_i + 32'd4;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (pred_valid_o) begin
            pred_count <= pred_count + 1;
        end
        if (cycle_count >= MAX_CYCLES) begin
            abort_run("timeout: the test did not finish within the cycle limit");
        end
    end

    a_valid: assert property (@(posedge clk) disable iff (!rst_n_i) pred_valid_o == exp_valid)
        else abort_run($sformatf("Mismatch pred_valid_o expected %h got %h",
                                 $sampled(exp_valid), $sampled(pred_valid_o)));
    a_hit: assert property (@(posedge clk) disable iff (!rst_n_i)
                            pred_valid_o |-> pred_hit_o == exp_hit)
        else abort_run($sformatf("Mismatch pred_hit_o expected %h got %h",
                                 $sampled(exp_hit), $sampled(pred_hit_o)));
    a_taken: assert property (@(posedge clk) disable iff (!rst_n_i)
                              pred_valid_o |-> pred_taken_o == exp_taken)
        else abort_run($sformatf("Mismatch pred_taken_o expected %h got %h",
                                 $sampled(exp_taken), $sampled(pred_taken_o)));
    a_target: assert property (@(posedge clk) disable iff (!rst_n_i)
                               pred_valid_o |-> pred_target_o == exp_target)
        else abort_run($sformatf("Mismatch pred_target_o expected %h got %h",
                                 $sampled(exp_target), $sampled(pred_target_o)));
    a_ctr: assert property (@(posedge clk) disable iff (!rst_n_i)
                            pred_valid_o |-> pred_ctr_o == exp_ctr)
        else abort_run($sformatf("Mismatch pred_ctr_o expected %h got %h",
                                 $sampled(exp_ctr), $sampled(pred_ctr_o)));

    task automatic drive_cycle(input logic lk, input logic [31:0] lk_pc, input logic up,
                               input logic [31:0] up_pc, input logic up_taken,
                               input logic [31:0] up_target);
        @(negedge clk);
        lookup_i     = lk;
        lookup_pc_i  = lk_pc;
        upd_i        = up;
        upd_pc_i     = up_pc;
        upd_taken_i  = up_taken;
        upd_target_i = up_target;
        upd_ctr_i    = counter_of(pc_index(up_pc)); // counter the core was handed
    endtask

    task automatic lookup_only(input logic [31:0] pc);
        drive_cycle(1'b1, pc, 1'b0, 32'h0, 1'b0, 32'h0);
    endtask

    task automatic update_only(input logic [31:0] pc, input logic taken,
                               input logic [31:0] target);
        drive_cycle(1'b0, 32'h0, 1'b1, pc, taken, target);
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] lk_pc;
        logic [31:0] up_pc;
        logic [31:0] tgt;
        logic        lk;
        logic        up;

        rst_n_i      = 1'b0;
        lookup_i     = 1'b0;
        lookup_pc_i  = '0;
        upd_i        = 1'b0;
        upd_pc_i     = '0;
        upd_taken_i  = 1'b0;
        upd_target_i = '0;
        upd_ctr_i    = 2'd0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;

        for (int i = 0; i < 8; i++) begin
            lookup_only(PC_POOL[i]); // cold tables, back to back
        end
        update_only(PC_POOL[0], 1'b1, 32'h0000_8000);
        lookup_only(PC_POOL[0]);
        lookup_only(PC_POOL[1]); // same index, other tag
        repeat (4) begin
            update_only(PC_POOL[2], 1'b1, 32'h0000_4400);
            lookup_only(PC_POOL[2]);
        end
        repeat (5) begin
            update_only(PC_POOL[2], 1'b0, 32'h0);
            lookup_only(PC_POOL[2]);
        end
        update_only(PC_POOL[0], 1'b0, 32'h0); // btb entry must survive
        lookup_only(PC_POOL[0]);

        // same-cycle lookup and update to one index
        drive_cycle(1'b1, PC_POOL[6], 1'b1, PC_POOL[6], 1'b1, 32'h0000_9000);
        drive_cycle(1'b1, PC_POOL[6], 1'b1, PC_POOL[6], 1'b1, 32'h0000_9100);
        drive_cycle(1'b1, PC_POOL[6], 1'b1, PC_POOL[6], 1'b0, 32'h0);
        drive_cycle(1'b1, PC_POOL[1], 1'b1, PC_POOL[1], 1'b1, 32'h0000_a000);
        lookup_only(PC_POOL[0]); // retagged, now a miss

        for (int n = 0; n < RAND_CYCLES; n++) begin
            r     = $random(seed);
            tgt   = $random(seed);
            tgt   = tgt & 32'hffff_fffc;
            lk_pc = PC_POOL[r[2:0]];
            up_pc = PC_POOL[r[5:3]];
            lk    = r[8:6] != 3'd0;
            up    = r[9];
            if (n % 16 == 0) begin
                up_pc = lk_pc; // forced collision
                lk    = 1'b1;
                up    = 1'b1;
            end
            drive_cycle(lk, lk_pc, up, up_pc, r[11:10] != 2'd0, tgt);
        end
        drive_cycle(1'b0, 32'h0, 1'b0, 32'h0, 1'b0, 32'h0);
        repeat (3) @(posedge clk);

        if (pred_count > 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            abort_run("no prediction was observed");
        end
    end

endmodule

// ==== logic/bpu_pkg.sv ====
package bpu_pkg;

    // pc and target width
    parameter int unsigned XLEN = 32;

    // two-bit saturating counter, upper bit means taken
    typedef logic [1:0] ctr_t;

    parameter ctr_t CTR_MIN  = 2'd0; // strongly not taken
    parameter ctr_t CTR_MAX  = 2'd3; // strongly taken
    parameter ctr_t CTR_INIT = 2'd1; // weakly not taken, never written

    // fall-through step and pc offset
    parameter logic [XLEN-1:0] INST_BYTES = 32'd4;

endpackage

// ==== logic/bpu_top.sv ====
module bpu_top #(
    parameter int IDX_W = 6
) (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  logic                     lookup_i,
    input  logic [bpu_pkg::XLEN-1:0] lookup_pc_i,
    input  logic                     upd_i,
    input  logic [bpu_pkg::XLEN-1:0] upd_pc_i,
    input  logic                     upd_taken_i,
    input  logic [bpu_pkg::XLEN-1:0] upd_target_i,
    input  bpu_pkg::ctr_t            upd_ctr_i,
    output logic                     pred_valid_o,
    output logic                     pred_hit_o,
    output logic                     pred_taken_o,
    output logic [bpu_pkg::XLEN-1:0] pred_target_o,
    output bpu_pkg::ctr_t            pred_ctr_o
);

    localparam int OFF_W = $clog2(bpu_pkg::INST_BYTES);
    localparam int TAG_W = bpu_pkg::XLEN - IDX_W - OFF_W;

    logic [IDX_W-1:0]         lk_idx;
    logic [TAG_W-1:0]         lk_tag;
    logic [IDX_W-1:0]         up_idx;
    logic [TAG_W-1:0]         up_tag;
    logic                     lookup_q;
    logic [bpu_pkg::XLEN-1:0] pc_q;
    logic                     btb_hit;
    logic [bpu_pkg::XLEN-1:0] btb_target;
    bpu_pkg::ctr_t            pht_ctr;

    assign lk_idx = lookup_pc_i[IDX_W+OFF_W-1:OFF_W];
    assign lk_tag = lookup_pc_i[bpu_pkg::XLEN-1:IDX_W+OFF_W];
    assign up_idx = upd_pc_i[IDX_W+OFF_W-1:OFF_W];
    assign up_tag = upd_pc_i[bpu_pkg::XLEN-1:IDX_W+OFF_W];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            lookup_q <= 1'b0;
        end else begin
            lookup_q <= lookup_i;
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_i) begin
            pc_q <= lookup_pc_i; // for the fall-through target
        end
    end

    btb #(
        .IDX_W (IDX_W)
    ) u_btb (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .rd_en_i     (lookup_i),
        .rd_idx_i    (lk_idx),
        .rd_tag_i    (lk_tag),
        .wr_en_i     (upd_i && upd_taken_i), // taken branches only
        .wr_idx_i    (up_idx),
        .wr_tag_i    (up_tag),
        .wr_target_i (upd_target_i),
        .hit_o       (btb_hit),
        .target_o    (btb_target)
    );

    pht #(
        .IDX_W (IDX_W)
    ) u_pht (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .rd_en_i   (lookup_i),
        .rd_idx_i  (lk_idx),
        .wr_en_i   (upd_i),
        .wr_idx_i  (up_idx),
        .taken_i   (upd_taken_i),
        .old_ctr_i (upd_ctr_i),
        .ctr_o     (pht_ctr)
    );

    assign pred_valid_o  = lookup_q;
    assign pred_hit_o    = btb_hit;
    assign pred_taken_o  = btb_hit && pht_ctr[1];
    assign pred_target_o = btb_hit ? btb_target : pc_q + bpu_pkg::INST_BYTES;
    assign pred_ctr_o    = pht_ctr;

endmodule

// ==== logic/btb.sv ====
module btb #(
    parameter int   IDX_W = 6,
    localparam int  TAG_W = bpu_pkg::XLEN - IDX_W - $clog2(bpu_pkg::INST_BYTES)
) (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  logic                     rd_en_i,
    input  logic [IDX_W-1:0]         rd_idx_i,
    input  logic [TAG_W-1:0]         rd_tag_i,
    input  logic                     wr_en_i,
    input  logic [IDX_W-1:0]         wr_idx_i,
    input  logic [TAG_W-1:0]         wr_tag_i,
    input  logic [bpu_pkg::XLEN-1:0] wr_target_i,
    output logic                     hit_o,
    output logic [bpu_pkg::XLEN-1:0] target_o
);

    localparam int DEPTH = 1 << IDX_W;

    typedef struct packed {
        logic [TAG_W-1:0]         tag;
        logic [bpu_pkg::XLEN-1:0] target;
    } btb_entry_t;

    logic [DEPTH-1:0] valid_q;
    logic             rd_valid_q;
    logic [TAG_W-1:0] rd_tag_q;
    logic             same_idx;
    btb_entry_t       wr_entry;
    btb_entry_t       rd_entry;

    assign same_idx = wr_en_i && (wr_idx_i == rd_idx_i);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (wr_en_i) begin
            valid_q[wr_idx_i] <= 1'b1;
        end
    end

    // valid bit read alongside the ram, forced on a colliding write
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_valid_q <= 1'b0;
        end else if (rd_en_i) begin
            rd_valid_q <= valid_q[rd_idx_i] | same_idx;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            rd_tag_q <= rd_tag_i;
        end
    end

    assign wr_entry.tag    = wr_tag_i;
    assign wr_entry.target = wr_target_i;

    bypass_ram #(
        .payload_t (btb_entry_t),
        .IDX_W     (IDX_W)
    ) u_ram (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .wr_en_i   (wr_en_i),
        .wr_idx_i  (wr_idx_i),
        .wr_data_i (wr_entry),
        .rd_en_i   (rd_en_i),
        .rd_idx_i  (rd_idx_i),
        .rd_data_o (rd_entry)
    );

    assign hit_o    = rd_valid_q && (rd_entry.tag == rd_tag_q);
    assign target_o = rd_entry.target; // only meaningful on a hit

endmodule

// ==== logic/bypass_ram.sv ====
module bypass_ram #(
    parameter type payload_t = logic,
    parameter int  IDX_W     = 6
) (
    input  logic             clk,
    input  logic             rst_n_i,
    input  logic             wr_en_i,
    input  logic [IDX_W-1:0] wr_idx_i,
    input  payload_t         wr_data_i,
    input  logic             rd_en_i,
    input  logic [IDX_W-1:0] rd_idx_i,
    output payload_t         rd_data_o
);

    logic     collide;
    logic     collide_q;
    payload_t wr_data_q;
    payload_t arr_data;

    assign collide = wr_en_i && rd_en_i && (wr_idx_i == rd_idx_i);

    // flag follows each read so the output holds between reads
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            collide_q <= 1'b0;
        end else if (rd_en_i) begin
            collide_q <= collide;
        end
    end

    always_ff @(posedge clk) begin
        if (collide) begin
            wr_data_q <= wr_data_i; // forwarded next cycle
        end
    end

    ram_array #(
        .payload_t (payload_t),
        .IDX_W     (IDX_W)
    ) u_array (
        .clk       (clk),
        .wr_en_i   (wr_en_i),
        .wr_idx_i  (wr_idx_i),
        .wr_data_i (wr_data_i),
        .rd_en_i   (rd_en_i),
        .rd_idx_i  (rd_idx_i),
        .rd_data_o (arr_data)
    );

    assign rd_data_o = collide_q ? wr_data_q : arr_data;

endmodule

// ==== logic/pht.sv ====
module pht #(
    parameter int IDX_W = 6
) (
    input  logic             clk,
    input  logic             rst_n_i,
    input  logic             rd_en_i,
    input  logic [IDX_W-1:0] rd_idx_i,
    input  logic             wr_en_i,
    input  logic [IDX_W-1:0] wr_idx_i,
    input  logic             taken_i,
    input  bpu_pkg::ctr_t    old_ctr_i,
    output bpu_pkg::ctr_t    ctr_o
);

    localparam int DEPTH = 1 << IDX_W;

    logic [DEPTH-1:0] written_q;
    logic             rd_written_q;
    logic             same_idx;
    bpu_pkg::ctr_t    next_ctr;
    bpu_pkg::ctr_t    rd_ctr;

    // step toward the outcome, saturating at both ends
    always_comb begin
        next_ctr = old_ctr_i;
        if (taken_i) begin
            if (old_ctr_i != bpu_pkg::CTR_MAX) begin
                next_ctr = old_ctr_i + 2'd1;
            end
        end else if (old_ctr_i != bpu_pkg::CTR_MIN) begin
            next_ctr = old_ctr_i - 2'd1;
        end
    end

    assign same_idx = wr_en_i && (wr_idx_i == rd_idx_i);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            written_q <= '0;
        end else if (wr_en_i) begin
            written_q[wr_idx_i] <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_written_q <= 1'b0;
        end else if (rd_en_i) begin
            rd_written_q <= written_q[rd_idx_i] | same_idx; // same-cycle write counts
        end
    end

    bypass_ram #(
        .payload_t (bpu_pkg::ctr_t),
        .IDX_W     (IDX_W)
    ) u_ram (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .wr_en_i   (wr_en_i),
        .wr_idx_i  (wr_idx_i),
        .wr_data_i (next_ctr),
        .rd_en_i   (rd_en_i),
        .rd_idx_i  (rd_idx_i),
        .rd_data_o (rd_ctr)
    );

    assign ctr_o = rd_written_q ? rd_ctr : bpu_pkg::CTR_INIT;

endmodule

// ==== logic/ram_array.sv ====
module ram_array #(
    parameter type payload_t = logic,
    parameter int  IDX_W     = 6
) (
    input  logic             clk,
    input  logic             wr_en_i,
    input  logic [IDX_W-1:0] wr_idx_i,
    input  payload_t         wr_data_i,
    input  logic             rd_en_i,
    input  logic [IDX_W-1:0] rd_idx_i,
    output payload_t         rd_data_o
);

    localparam int DEPTH = 1 << IDX_W;

    payload_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_idx_i] <= wr_data_i;
        end
    end

    // registered read, holds when idle
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            rd_data_o <= mem[rd_idx_i]; // old word on same-cycle write
        end
    end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f compile.f --top-module bpu_tb -Mdir obj_dir -o bpu_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/bpu_sim 2>&1 | tee sim.log
if [ "${PIPESTATUS[0]}" -ne 0 ]; then
    echo "simulation ended with an error status"
    exit 1
fi

if grep -q "ALL CHECKS PASSED" sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "pass line missing from sim.log"
exit 1
